// File: exec_unit.f
hw/exu_pkg.sv
hw/int_alu.sv
hw/shift_add_multiplier.sv
hw/radix2_divider.sv
hw/exec_control.sv
hw/exec_unit.sv
verif/tb_exec_unit.sv

// File: verif/tb_exec_unit.sv
module tb_exec_unit;
    timeunit 1ns;
    timeprecision 1ps;

    import exu_pkg::*;

    localparam int STALL_LIMIT = 40;
    localparam int CYCLE_LIMIT = 300 + 100 * 40 + 100 * 40 + 500;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [31:0] src_a;
    logic [31:0] src_b;
    logic [4:0]  sa;
    alu_op_e     alu_op;
    logic [63:0] hilo;
    logic        start;
    logic        flush;
    logic [63:0] result;
    logic        overflow;
    logic        mult_stall;
    logic        div_stall;

    integer seed = 32'h3d44be8f;
    int     checks = 0;
    int     errors = 0;
    int     cycles = 0;

    always #10 clk = ~clk;

    exec_unit #(
        .MULT_STEP (2)
    ) u_exec_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .src_a      (src_a),
        .src_b      (src_b),
        .sa         (sa),
        .alu_op     (alu_op),
        .hilo       (hilo),
        .start      (start),
        .flush      (flush),
        .result     (result),
        .overflow   (overflow),
        .mult_stall (mult_stall),
        .div_stall  (div_stall)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without finishing", CYCLE_LIMIT);
            $display("Something failed");
            $finish;
        end
    end

    // expected {overflow, result}
    function automatic logic [64:0] model(input alu_op_e op, input logic [31:0] a,
                                          input logic [31:0] b, input logic [4:0] s,
                                          input logic [63:0] hl);
        longint          sa_l;
        longint          sb_l;
        longint          wide;
        longint unsigned ua;
        longint unsigned ub;
        logic [31:0]     w;
        logic [63:0]     res;
        logic            ovf;
        sa_l = longint'($signed(a));
        sb_l = longint'($signed(b));
        ua   = a;
        ub   = b;
        w    = 32'h0;
        res  = 64'h0;
        ovf  = 1'b0;
        case (op)
            alu_and:    w = a & b;
            alu_or:     w = a | b;
            alu_nor:    w = ~(a | b);
            alu_xor:    w = a ^ b;
            alu_addu:   w = a + b;
            alu_subu:   w = a - b;
            alu_slt:    w = {31'h0, (sa_l < sb_l)};
            alu_sltu:   w = {31'h0, (a < b)};
            alu_sllv:   w = b << a[4:0];
            alu_sll:    w = b << s;
            alu_srlv:   w = b >> a[4:0];
            alu_srl:    w = b >> s;
            alu_srav:   w = 32'(sb_l >>> a[4:0]);  // sign-extended source
            alu_sra:    w = 32'(sb_l >>> s);
            alu_lui:    w = {b[15:0], 16'h0};
            alu_pass_a: w = a;
            alu_add, alu_sub: begin
                wide = (op == alu_add) ? sa_l + sb_l : sa_l - sb_l;
                w    = 32'(wide);
                ovf  = (wide != longint'($signed(w)));
            end
            default: w = 32'h0;
        endcase
        res = {32'h0, w};
        case (op)
            alu_mult:  res = 64'(sa_l * sb_l);
            alu_multu: res = ua * ub;
            alu_div:   res = {32'(sa_l % sb_l), 32'(sa_l / sb_l)};
            alu_divu:  res = {a % b, a / b};
            alu_mthi:  res = {a, hl[31:0]};
            alu_mtlo:  res = {hl[63:32], a};
            default:   res = res;
        endcase
        return {ovf, res};
    endfunction

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [31:0] edge_word();
        logic [2:0] pick;
        pick = 3'($random(seed));
        case (pick)
            3'd0:    return 32'h8000_0000;
            3'd1:    return 32'hffff_ffff;
            3'd2:    return 32'h0000_0000;
            3'd3:    return 32'h7fff_ffff;
            default: return $random(seed);
        endcase
    endfunction

    function automatic logic stall_of(input alu_op_e op);
        return (op inside {alu_mult, alu_multu}) ? mult_stall : div_stall;
    endfunction

    task automatic check_outputs(input string what);
        logic [64:0] exp;
        exp = model(alu_op, src_a, src_b, sa, hilo);
        checks++;
        if (result !== exp[63:0] || overflow !== exp[64]) begin
            errors++;
            $display("Error at %0t: %s %s a=%h b=%h sa=%0d got %h ovf %b, expected %h ovf %b",
                     $time, what, alu_op.name(), src_a, src_b, sa, result, overflow,
                     exp[63:0], exp[64]);
        end
    endtask

    task automatic check_stall(input string what, input logic got, input logic want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Error at %0t: %s is %b, expected %b", $time, what, got, want);
        end
    endtask

    task automatic run_single(input alu_op_e op, input logic [31:0] a, input logic [31:0] b,
                              input logic [4:0] s, input string what);
        @(posedge clk);
        alu_op <= op;
        src_a  <= a;
        src_b  <= b;
        sa     <= s;
        start  <= 1'b0;
        @(negedge clk);
        check_outputs(what);
    endtask

    task automatic run_muldiv(input alu_op_e op, input logic [31:0] a, input logic [31:0] b);
        int waited;
        waited = 0;
        @(posedge clk);
        alu_op <= op;
        src_a  <= a;
        src_b  <= b;
        start  <= 1'b1;
        @(negedge clk);
        check_stall("stall in start cycle", stall_of(op), 1'b1);
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        while (stall_of(op) && waited < STALL_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (stall_of(op)) begin
            checks++;
            errors++;
            $display("stall for %s stayed high for %0d cycles", op.name(), STALL_LIMIT);
        end else begin
            check_outputs("muldiv");
        end
    endtask

    task automatic report_test(input string name, input int checks_before,
                               input int errors_before);
        $display("%s: %0d checks, %0d errors", name, checks - checks_before,
                 errors - errors_before);
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  amt;
        logic [4:0]  imm;
        alu_op_e     op;
        int          idx;
        int          c0;
        int          e0;
        rst_n  = 1'b0;
        src_a  = 32'h0;
        src_b  = 32'h0;
        sa     = 5'h0;
        alu_op = alu_and;
        hilo   = 64'h0;
        start  = 1'b0;
        flush  = 1'b0;

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_stall("mult_stall after reset", mult_stall, 1'b0);
        check_stall("div_stall after reset", div_stall, 1'b0);

        c0 = checks;
        e0 = errors;
        for (int i = 0; i < 200; i++) begin
            idx = $unsigned($random(seed)) % 11;
            op  = (idx == 10) ? alu_lui : alu_op_e'(5'(idx));
            run_single(op, edge_word(), edge_word(), 5'(rand_word()), "single");
        end
        report_test("random single-cycle ops", c0, e0);

        c0 = checks;
        e0 = errors;
        for (int i = 0; i < 100; i++) begin
            idx = $unsigned($random(seed)) % 6;
            op  = alu_op_e'(5'(10 + idx));
            idx = $unsigned($random(seed)) % 3;
            amt = (idx == 0) ? 5'd0 : (idx == 1) ? 5'd31 : 5'(rand_word());
            a   = rand_word();
            imm = 5'(rand_word());
            if (op inside {alu_sllv, alu_srlv, alu_srav}) begin
                a[4:0] = amt;  // variable amount in a[4:0]
            end else begin
                imm = amt;
            end
            run_single(op, a, edge_word(), imm, "shift");
        end
        report_test("shifts", c0, e0);

        c0 = checks;
        e0 = errors;
        for (int i = 0; i < 100; i++) begin
            op = ($random(seed) & 1) ? alu_mult : alu_multu;
            a  = edge_word();
            b  = edge_word();
            if (i < 2) begin
                a = 32'h8000_0000;
                b = (i == 0) ? 32'hffff_ffff : 32'h8000_0000;
            end
            run_muldiv(op, a, b);
        end
        report_test("multiply", c0, e0);

        c0 = checks;
        e0 = errors;
        for (int i = 0; i < 100; i++) begin
            op = ($random(seed) & 1) ? alu_div : alu_divu;
            a  = edge_word();
            b  = rand_word() >> ($unsigned($random(seed)) % 32);  // spread of quotient sizes
            if ($random(seed) & 1) begin
                b = -b;
            end
            if (b == 32'h0) begin
                b = 32'h1;
            end
            run_muldiv(op, a, b);
        end
        report_test("divide", c0, e0);

        c0 = checks;
        e0 = errors;
        for (int i = 0; i < 20; i++) begin
            @(posedge clk);
            hilo <= {rand_word(), rand_word()};
            op = (i % 2 == 0) ? alu_mthi : alu_mtlo;
            run_single(op, rand_word(), rand_word(), 5'h0, "move");
            check_stall("mult_stall on move", mult_stall, 1'b0);
            check_stall("div_stall on move", div_stall, 1'b0);
        end
        report_test("mthi/mtlo", c0, e0);

        c0 = checks;
        e0 = errors;
        @(posedge clk);
        alu_op <= alu_div;
        src_a  <= rand_word();
        src_b  <= 32'h0000_0007;
        start  <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_stall("div_stall before flush", div_stall, 1'b1);
        @(posedge clk);
        flush <= 1'b1;
        @(negedge clk);
        check_stall("div_stall in flush cycle", div_stall, 1'b0);
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        check_stall("div_stall after flush", div_stall, 1'b0);
        check_stall("mult_stall after flush", mult_stall, 1'b0);
        run_muldiv(alu_div, 32'hffff_ff9c, 32'h0000_0007);
        run_muldiv(alu_divu, rand_word(), 32'h0000_0003);
        report_test("flush", c0, e0);

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: hw/exec_unit.sv
module exec_unit #(
    parameter int MULT_STEP = 2
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [exu_pkg::XLEN-1:0]   src_a,
    input  logic [exu_pkg::XLEN-1:0]   src_b,
    input  logic [4:0]                 sa,
    input  exu_pkg::alu_op_e           alu_op,
    input  logic [2*exu_pkg::XLEN-1:0] hilo,
    input  logic                       start,
    input  logic                       flush,
    output logic [2*exu_pkg::XLEN-1:0] result,
    output logic                       overflow,
    output logic                       mult_stall,
    output logic                       div_stall
);
    import exu_pkg::*;

    logic [XLEN-1:0] alu_result;
    logic            alu_ovf;
    logic            mul_launch;
    logic            mul_signed;
    logic            mul_done;
    logic            div_launch;
    logic            div_signed;
    logic            div_done;
    hilo_t           product;
    hilo_t           quot_rem;

    int_alu u_int_alu (
        .src_a      (src_a),
        .src_b      (src_b),
        .sa         (sa),
        .alu_op     (alu_op),
        .alu_result (alu_result),
        .alu_ovf    (alu_ovf)
    );

    shift_add_multiplier #(
        .MULT_STEP (MULT_STEP)
    ) u_multiplier (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .launch    (mul_launch),
        .is_signed (mul_signed),
        .a         (src_a),
        .b         (src_b),
        .done      (mul_done),
        .product   (product)
    );

    radix2_divider u_divider (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .launch    (div_launch),
        .is_signed (div_signed),
        .dividend  (src_a),
        .divisor   (src_b),
        .done      (div_done),
        .quot_rem  (quot_rem)
    );

    exec_control u_exec_control (
        .clk        (clk),
        .rst_n      (rst_n),
        .alu_op     (alu_op),
        .start      (start),
        .flush      (flush),
        .src_a      (src_a),
        .hilo       (hilo),
        .alu_result (alu_result),
        .alu_ovf    (alu_ovf),
        .mul_done   (mul_done),
        .div_done   (div_done),
        .product    (product),
        .quot_rem   (quot_rem),
        .mul_launch (mul_launch),
        .mul_signed (mul_signed),
        .div_launch (div_launch),
        .div_signed (div_signed),
        .result     (result),
        .overflow   (overflow),
        .mult_stall (mult_stall),
        .div_stall  (div_stall)
    );

endmodule

// File: hw/exec_control.sv
module exec_control (
    input  logic                     clk,
    input  logic                     rst_n,
    input  exu_pkg::alu_op_e         alu_op,
    input  logic                     start,
    input  logic                     flush,
    input  logic [exu_pkg::XLEN-1:0] src_a,
    input  exu_pkg::hilo_t           hilo,
    input  logic [exu_pkg::XLEN-1:0] alu_result,
    input  logic                     alu_ovf,
    input  logic                     mul_done,
    input  logic                     div_done,
    input  exu_pkg::hilo_t           product,
    input  exu_pkg::hilo_t           quot_rem,
    output logic                     mul_launch,
    output logic                     mul_signed,
    output logic                     div_launch,
    output logic                     div_signed,
    output exu_pkg::hilo_t           result,
    output logic                     overflow,
    output logic                     mult_stall,
    output logic                     div_stall
);
    import exu_pkg::*;

    logic is_mul;
    logic is_div;
    logic mul_pend;
    logic div_pend;

    assign is_mul     = alu_op inside {alu_mult, alu_multu};
    assign is_div     = alu_op inside {alu_div, alu_divu};
    assign mul_signed = (alu_op == alu_mult);
    assign div_signed = (alu_op == alu_div);

    assign mul_launch = start && is_mul && !flush;
    assign div_launch = start && is_div && !flush;

    // set on launch, dropped by done or flush
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mul_pend <= 1'b0;
            div_pend <= 1'b0;
        end else if (flush) begin
            mul_pend <= 1'b0;
            div_pend <= 1'b0;
        end else begin
            if (mul_launch) begin
                mul_pend <= 1'b1;
            end else if (mul_done) begin
                mul_pend <= 1'b0;
            end
            if (div_launch) begin
                div_pend <= 1'b1;
            end else if (div_done) begin
                div_pend <= 1'b0;
            end
        end
    end

    // released in the done cycle
    assign mult_stall = is_mul && !flush && (mul_launch || (mul_pend && !mul_done));
    assign div_stall  = is_div && !flush && (div_launch || (div_pend && !div_done));

    assign overflow = alu_ovf;  // set by add/sub only

    always_comb begin
        case (alu_op)
            alu_mult, alu_multu: begin
                result = product;
            end
            alu_div, alu_divu: begin
                result = quot_rem;
            end
            alu_mthi: begin
                result.half.hi = src_a;
                result.half.lo = hilo.half.lo;
            end
            alu_mtlo: begin
                result.half.hi = hilo.half.hi;
                result.half.lo = src_a;
            end
            default: begin
                result.word = {{XLEN{1'b0}}, alu_result};
            end
        endcase
    end

    a_start_muldiv_only: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> (is_mul || is_div));

endmodule

// File: hw/radix2_divider.sv
module radix2_divider (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     flush,
    input  logic                     launch,
    input  logic                     is_signed,
    input  logic [exu_pkg::XLEN-1:0] dividend,
    input  logic [exu_pkg::XLEN-1:0] divisor,
    output logic                     done,
    output exu_pkg::hilo_t           quot_rem
);
    import exu_pkg::*;

    localparam int CNT_W = $clog2(XLEN);

    logic              busy;
    logic [CNT_W-1:0]  iter_cnt;
    logic              last_iter;
    logic              q_neg;
    logic              r_neg;
    logic [XLEN-1:0]   mag_dvd;
    logic [XLEN-1:0]   mag_dvs;
    logic [XLEN-1:0]   dvs;
    logic [XLEN-1:0]   dq;
    logic [XLEN-1:0]   rem;
    logic [XLEN:0]     partial;
    logic [XLEN+1:0]   diff;
    logic [XLEN-1:0]   rem_next;
    logic [XLEN-1:0]   dq_next;

    assign mag_dvd = (is_signed && dividend[XLEN-1]) ? -dividend : dividend;
    assign mag_dvs = (is_signed && divisor[XLEN-1]) ? -divisor : divisor;

    // dq shifts the dividend out and the quotient in
    assign partial  = {rem, dq[XLEN-1]};
    assign diff     = {1'b0, partial} - {2'b00, dvs};
    assign rem_next = diff[XLEN+1] ? partial[XLEN-1:0] : diff[XLEN-1:0];  // restore
    assign dq_next  = {dq[XLEN-2:0], ~diff[XLEN+1]};

    assign last_iter = busy && (iter_cnt == CNT_W'(XLEN - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            iter_cnt <= '0;
            done     <= 1'b0;
        end else if (flush) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= last_iter;
            if (launch) begin
                busy     <= 1'b1;
                iter_cnt <= '0;
            end else if (last_iter) begin
                busy <= 1'b0;
            end else if (busy) begin
                iter_cnt <= iter_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            dvs   <= mag_dvs;
            dq    <= mag_dvd;
            rem   <= '0;
            q_neg <= is_signed && (dividend[XLEN-1] ^ divisor[XLEN-1]);
            r_neg <= is_signed && dividend[XLEN-1];  // remainder follows dividend
        end else if (busy) begin
            dq  <= dq_next;
            rem <= rem_next;
        end
        if (last_iter && !flush) begin
            quot_rem.half.hi <= r_neg ? -rem_next : rem_next;
            quot_rem.half.lo <= q_neg ? -dq_next : dq_next;
        end
    end

    // pipeline is frozen while a divide runs
    a_no_launch_busy: assert property (@(posedge clk) disable iff (!rst_n)
        launch |-> !busy);

    a_done_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> !busy);

endmodule

// File: hw/shift_add_multiplier.sv
module shift_add_multiplier #(
    parameter int MULT_STEP = 2
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     flush,
    input  logic                     launch,
    input  logic                     is_signed,
    input  logic [exu_pkg::XLEN-1:0] a,
    input  logic [exu_pkg::XLEN-1:0] b,
    output logic                     done,
    output exu_pkg::hilo_t           product
);
    import exu_pkg::*;

    localparam int N_STEPS = XLEN / MULT_STEP;
    localparam int CNT_W   = $clog2(N_STEPS);

    logic              busy;
    logic [CNT_W-1:0]  step_cnt;
    logic              last_step;
    logic              armed;
    logic              neg;
    logic [XLEN-1:0]   mag_a;
    logic [XLEN-1:0]   mag_b;
    logic [2*XLEN-1:0] mcand;
    logic [XLEN-1:0]   mplier;
    logic [2*XLEN-1:0] acc;
    logic [2*XLEN-1:0] acc_next;

    if (!(MULT_STEP inside {1, 2, 4})) begin : g_step_check
        $error("MULT_STEP must be 1, 2 or 4");
    end

    assign mag_a     = (is_signed && a[XLEN-1]) ? -a : a;
    assign mag_b     = (is_signed && b[XLEN-1]) ? -b : b;
    assign last_step = busy && (step_cnt == CNT_W'(N_STEPS - 1));

    // MULT_STEP partial products per cycle
    always_comb begin
        acc_next = acc;
        for (int i = 0; i < MULT_STEP; i++) begin
            if (mplier[i]) begin
                acc_next = acc_next + (mcand << i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            step_cnt <= '0;
            done     <= 1'b0;
        end else if (flush) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= last_step;
            if (launch) begin
                busy     <= 1'b1;
                step_cnt <= '0;
            end else if (last_step) begin
                busy <= 1'b0;
            end else if (busy) begin
                step_cnt <= step_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            mcand  <= {{XLEN{1'b0}}, mag_a};
            mplier <= mag_b;
            acc    <= '0;
            neg    <= is_signed && (a[XLEN-1] ^ b[XLEN-1]);
        end else if (busy) begin
            mcand  <= mcand << MULT_STEP;
            mplier <= mplier >> MULT_STEP;
            acc    <= acc_next;
        end
        if (last_step && !flush) begin
            product.word <= neg ? -acc_next : acc_next;  // sign fix on the last sum
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            armed <= 1'b0;
        end else if (launch) begin
            armed <= 1'b1;
        end else if (done || flush) begin
            armed <= 1'b0;
        end
    end

    a_done_after_launch: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> armed);

endmodule

// File: hw/int_alu.sv
module int_alu (
    input  logic [exu_pkg::XLEN-1:0] src_a,
    input  logic [exu_pkg::XLEN-1:0] src_b,
    input  logic [4:0]               sa,
    input  exu_pkg::alu_op_e         alu_op,
    output logic [exu_pkg::XLEN-1:0] alu_result,
    output logic                     alu_ovf
);
    import exu_pkg::*;

    logic              do_sub;
    logic [XLEN-1:0]   adder_b;
    logic [XLEN-1:0]   sum;
    logic              carry_out;
    logic              slt_bit;
    logic              sltu_bit;
    logic              var_shift;
    logic              arith_shift;
    logic [4:0]        shamt;
    logic [2*XLEN-1:0] sr_ext;
    logic [XLEN-1:0]   sr_result;
    logic [XLEN-1:0]   sl_result;
    logic [XLEN-1:0]   lui_result;

    // one adder shared by add/sub and both compares
    assign do_sub  = alu_op inside {alu_sub, alu_subu, alu_slt, alu_sltu};
    assign adder_b = src_b ^ {XLEN{do_sub}};

    assign {carry_out, sum} = {1'b0, src_a} + {1'b0, adder_b} + {{XLEN{1'b0}}, do_sub};

    // same-sign operands, result sign flipped
    assign alu_ovf = (alu_op inside {alu_add, alu_sub})
                     && (src_a[XLEN-1] == adder_b[XLEN-1])
                     && (sum[XLEN-1] != src_a[XLEN-1]);

    assign slt_bit  = (src_a[XLEN-1] & ~src_b[XLEN-1])
                      | (~(src_a[XLEN-1] ^ src_b[XLEN-1]) & sum[XLEN-1]);
    assign sltu_bit = ~carry_out;  // borrow out means a < b

    assign var_shift   = alu_op inside {alu_sllv, alu_srlv, alu_srav};
    assign arith_shift = alu_op inside {alu_srav, alu_sra};
    assign shamt       = var_shift ? src_a[4:0] : sa;

    assign sr_ext    = {{XLEN{arith_shift & src_b[XLEN-1]}}, src_b} >> shamt;
    assign sr_result = sr_ext[XLEN-1:0];
    assign sl_result = src_b << shamt;

    assign lui_result = {src_b[XLEN/2-1:0], {(XLEN/2){1'b0}}};

    always_comb begin
        case (alu_op)
            alu_and: begin
                alu_result = src_a & src_b;
            end
            alu_or: begin
                alu_result = src_a | src_b;
            end
            alu_nor: begin
                alu_result = ~(src_a | src_b);
            end
            alu_xor: begin
                alu_result = src_a ^ src_b;
            end
            alu_add, alu_addu, alu_sub, alu_subu: begin
                alu_result = sum;
            end
            alu_slt: begin
                alu_result = {{(XLEN-1){1'b0}}, slt_bit};
            end
            alu_sltu: begin
                alu_result = {{(XLEN-1){1'b0}}, sltu_bit};
            end
            alu_sllv, alu_sll: begin
                alu_result = sl_result;
            end
            alu_srlv, alu_srav, alu_srl, alu_sra: begin
                alu_result = sr_result;
            end
            alu_lui: begin
                alu_result = lui_result;
            end
            alu_pass_a: begin
                alu_result = src_a;
            end
            default: begin
                alu_result = '0;  // mul/div and hi/lo moves merged later
            end
        endcase
    end

endmodule

// File: hw/exu_pkg.sv
package exu_pkg;

    parameter int XLEN = 32;

    // execute-stage operation codes
    typedef enum logic [4:0] {
        alu_and    = 5'd0,
        alu_or     = 5'd1,
        alu_nor    = 5'd2,
        alu_xor    = 5'd3,
        alu_add    = 5'd4,
        alu_addu   = 5'd5,
        alu_sub    = 5'd6,
        alu_subu   = 5'd7,
        alu_slt    = 5'd8,
        alu_sltu   = 5'd9,
        alu_sllv   = 5'd10,  // amount from src_a
        alu_sll    = 5'd11,  // amount from sa
        alu_srlv   = 5'd12,
        alu_srav   = 5'd13,
        alu_srl    = 5'd14,
        alu_sra    = 5'd15,
        alu_lui    = 5'd16,
        alu_pass_a = 5'd17,
        alu_mult   = 5'd18,
        alu_multu  = 5'd19,
        alu_div    = 5'd20,
        alu_divu   = 5'd21,
        alu_mthi   = 5'd22,
        alu_mtlo   = 5'd23
    } alu_op_e;

    typedef struct packed {
        logic [XLEN-1:0] hi;  // remainder for divide
        logic [XLEN-1:0] lo;  // quotient for divide
    } hilo_pair_t;

    // full product or hi/lo pair
    typedef union packed {
        logic [2*XLEN-1:0] word;
        hilo_pair_t        half;
    } hilo_t;

endpackage
